// File: hdl/clock_pkg.sv
`default_nettype none

package clock_pkg;

  // Field and display types
  typedef logic [5:0] time_field_t;
  typedef logic [3:0] bcd_digit_t;
  // Segments a..g, a in the msb, active high
  typedef logic [6:0] seg_pattern_t;

  localparam int NUM_DIGITS = 6;
  // Active low, bit 0 drives the rightmost digit
  typedef logic [NUM_DIGITS-1:0] digit_enable_t;

  typedef enum logic [1:0] {
    MODE_CLOCK = 2'd0,
    MODE_SETUP = 2'd1,
    MODE_ALARM = 2'd2
  } clock_mode_t;

  typedef enum logic [1:0] {
    POS_SEC  = 2'd0,
    POS_MIN  = 2'd1,
    POS_HOUR = 2'd2
  } set_pos_t;

  localparam time_field_t SEC_MAX  = 6'd59;
  localparam time_field_t MIN_MAX  = 6'd59;
  localparam time_field_t HOUR_MAX = 6'd23;

  // Defaults for a 50 MHz system clock
  localparam int DEF_TICKS_PER_SEC = 50_000_000;
  // 1 kHz digit step, whole frame near 167 Hz
  localparam int DEF_SCAN_DIV      = 50_000;
  // 10 ms between button samples
  localparam int DEF_DEBOUNCE_DIV  = 500_000;

  localparam seg_pattern_t SEG_BLANK = 7'b000_0000;

endpackage

`default_nettype wire

// File: hdl/tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tick_gen #(
  parameter int DIV = 4
) (
  input  logic clk,
  input  logic rst_n,
  output logic o_tick
);

  localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV - 1);

  logic [CNT_W-1:0] cnt;

  // Pulse is registered, so the first one lands DIV cycles after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt    <= '0;
      o_tick <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt    <= '0;
      o_tick <= 1'b1;
    end else begin
      cnt    <= cnt + 1'b1;
      o_tick <= 1'b0;
    end
  end

  if (DIV > 1) begin : g_tick_check
    a_tick_single: assert property (
      @(posedge clk) disable iff (!rst_n) o_tick |=> !o_tick);
  end

endmodule

`default_nettype wire

// File: hdl/button_sync.sv
`timescale 1ns/10ps
`default_nettype none

module button_sync (
  input  logic clk,
  input  logic rst_n,
  input  logic i_btn,
  input  logic i_sample_tick,
  output logic o_press
);

  logic btn_meta;
  logic btn_sync;
  logic btn_sampled;

  // Two flop synchronizer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      btn_meta <= 1'b0;
      btn_sync <= 1'b0;
    end else begin
      btn_meta <= i_btn;
      btn_sync <= btn_meta;
    end
  end

  // Slow sampling rides out contact bounce; one pulse per rising sample
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      btn_sampled <= 1'b0;
      o_press     <= 1'b0;
    end else if (i_sample_tick) begin
      btn_sampled <= btn_sync;
      o_press     <= btn_sync & ~btn_sampled;
    end else begin
      o_press <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/mode_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mode_ctrl
  import clock_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic i_sec_tick,
  input  logic i_mode_press,
  input  logic i_pos_press,
  input  logic i_inc_press,
  input  logic i_alarm_press,
  output logic o_time_run,
  output logic o_time_inc_sec,
  output logic o_time_inc_min,
  output logic o_time_inc_hour,
  output logic o_alarm_inc_sec,
  output logic o_alarm_inc_min,
  output logic o_alarm_inc_hour,
  output logic o_alarm_en,
  output logic o_show_alarm
);

  clock_mode_t mode;
  set_pos_t    pos;
  logic        alarm_en;
  logic        setup_inc;
  logic        alarm_inc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode     <= MODE_CLOCK;
      pos      <= POS_SEC;
      alarm_en <= 1'b0;
    end else begin
      if (i_mode_press) begin
        case (mode)
          MODE_CLOCK: mode <= MODE_SETUP;
          MODE_SETUP: mode <= MODE_ALARM;
          default:    mode <= MODE_CLOCK;
        endcase
      end
      if (i_pos_press) begin
        case (pos)
          POS_SEC: pos <= POS_MIN;
          POS_MIN: pos <= POS_HOUR;
          default: pos <= POS_SEC;
        endcase
      end
      if (i_alarm_press) begin
        alarm_en <= ~alarm_en;
      end
    end
  end

  // ------------------------------------------------------------------
  // Steering to the two counters
  // ------------------------------------------------------------------
  // Time of day keeps running while the alarm is being set
  assign o_time_run = i_sec_tick && (mode != MODE_SETUP);

  assign setup_inc = i_inc_press && (mode == MODE_SETUP);
  assign alarm_inc = i_inc_press && (mode == MODE_ALARM);

  assign o_time_inc_sec   = setup_inc && (pos == POS_SEC);
  assign o_time_inc_min   = setup_inc && (pos == POS_MIN);
  assign o_time_inc_hour  = setup_inc && (pos == POS_HOUR);
  assign o_alarm_inc_sec  = alarm_inc && (pos == POS_SEC);
  assign o_alarm_inc_min  = alarm_inc && (pos == POS_MIN);
  assign o_alarm_inc_hour = alarm_inc && (pos == POS_HOUR);

  assign o_alarm_en   = alarm_en;
  assign o_show_alarm = (mode == MODE_ALARM);

  a_inc_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({o_time_inc_sec, o_time_inc_min, o_time_inc_hour,
              o_alarm_inc_sec, o_alarm_inc_min, o_alarm_inc_hour}));

endmodule

`default_nettype wire

// File: hdl/hms_counter.sv
`timescale 1ns/10ps
`default_nettype none

module hms_counter
  import clock_pkg::*;
#(
  parameter bit FREE_RUN = 1'b1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_run,
  input  logic        i_inc_sec,
  input  logic        i_inc_min,
  input  logic        i_inc_hour,
  output time_field_t o_sec,
  output time_field_t o_min,
  output time_field_t o_hour
);

  logic run;

  function automatic time_field_t wrap_inc(time_field_t value, time_field_t max);
    return (value == max) ? '0 : value + 6'd1;
  endfunction

  // Alarm copy never advances by itself
  assign run = FREE_RUN && i_run;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_sec  <= '0;
      o_min  <= '0;
      o_hour <= '0;
    end else if (run) begin
      o_sec <= wrap_inc(o_sec, SEC_MAX);
      if (o_sec == SEC_MAX) begin
        o_min <= wrap_inc(o_min, MIN_MAX);
        if (o_min == MIN_MAX) begin
          o_hour <= wrap_inc(o_hour, HOUR_MAX);
        end
      end
    end else begin
      // Set increments touch only their own field, no carry
      if (i_inc_sec) begin
        o_sec <= wrap_inc(o_sec, SEC_MAX);
      end
      if (i_inc_min) begin
        o_min <= wrap_inc(o_min, MIN_MAX);
      end
      if (i_inc_hour) begin
        o_hour <= wrap_inc(o_hour, HOUR_MAX);
      end
    end
  end

  a_field_range: assert property (@(posedge clk) disable iff (!rst_n)
    (o_sec <= SEC_MAX) && (o_min <= MIN_MAX) && (o_hour <= HOUR_MAX));

endmodule

`default_nettype wire

// File: hdl/alarm_match.sv
`timescale 1ns/10ps
`default_nettype none

module alarm_match
  import clock_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_alarm_en,
  input  time_field_t i_sec,
  input  time_field_t i_min,
  input  time_field_t i_hour,
  input  time_field_t i_alarm_sec,
  input  time_field_t i_alarm_min,
  input  time_field_t i_alarm_hour,
  output logic        o_alarm
);

  logic time_match;

  assign time_match = (i_sec == i_alarm_sec) && (i_min == i_alarm_min) &&
                      (i_hour == i_alarm_hour);

  // Flag sticks after the match second; only disabling clears it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_alarm <= 1'b0;
    end else begin
      o_alarm <= i_alarm_en && (time_match || o_alarm);
    end
  end

endmodule

`default_nettype wire

// File: hdl/seg_display.sv
`timescale 1ns/10ps
`default_nettype none

module seg_display
  import clock_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          i_scan_tick,
  input  logic          i_show_alarm,
  input  time_field_t   i_sec,
  input  time_field_t   i_min,
  input  time_field_t   i_hour,
  input  time_field_t   i_alarm_sec,
  input  time_field_t   i_alarm_min,
  input  time_field_t   i_alarm_hour,
  output seg_pattern_t  o_seg,
  output digit_enable_t o_seg_enb
);

  localparam logic [2:0] IDX_LAST = 3'(NUM_DIGITS - 1);

  time_field_t sel_sec;
  time_field_t sel_min;
  time_field_t sel_hour;
  logic [2:0]  digit_idx;
  logic [2:0]  next_idx;
  logic [2:0]  cur_idx;
  bcd_digit_t  cur_digit;

  function automatic seg_pattern_t digit_to_seg(bcd_digit_t digit);
    case (digit)
      4'd0:    return 7'b111_1110;
      4'd1:    return 7'b011_0000;
      4'd2:    return 7'b110_1101;
      4'd3:    return 7'b111_1001;
      4'd4:    return 7'b011_0011;
      4'd5:    return 7'b101_1011;
      4'd6:    return 7'b101_1111;
      4'd7:    return 7'b111_0000;
      4'd8:    return 7'b111_1111;
      4'd9:    return 7'b111_0011;
      default: return SEG_BLANK;
    endcase
  endfunction

  assign sel_sec  = i_show_alarm ? i_alarm_sec  : i_sec;
  assign sel_min  = i_show_alarm ? i_alarm_min  : i_min;
  assign sel_hour = i_show_alarm ? i_alarm_hour : i_hour;

  // ------------------------------------------------------------------
  // Scan position, digit 0 is seconds ones
  // ------------------------------------------------------------------
  assign next_idx = (digit_idx == IDX_LAST) ? 3'd0 : digit_idx + 3'd1;
  // Look ahead on the tick so pattern and enable switch together
  assign cur_idx  = i_scan_tick ? next_idx : digit_idx;

  always_comb begin
    case (cur_idx)
      3'd0:    cur_digit = bcd_digit_t'(sel_sec % 6'd10);
      3'd1:    cur_digit = bcd_digit_t'(sel_sec / 6'd10);
      3'd2:    cur_digit = bcd_digit_t'(sel_min % 6'd10);
      3'd3:    cur_digit = bcd_digit_t'(sel_min / 6'd10);
      3'd4:    cur_digit = bcd_digit_t'(sel_hour % 6'd10);
      default: cur_digit = bcd_digit_t'(sel_hour / 6'd10);
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digit_idx <= 3'd0;
      o_seg     <= SEG_BLANK;
      o_seg_enb <= ~digit_enable_t'(1);
    end else begin
      digit_idx <= cur_idx;
      o_seg     <= digit_to_seg(cur_digit);
      o_seg_enb <= ~(digit_enable_t'(1) << cur_idx);
    end
  end

  a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
    $countones(o_seg_enb) == NUM_DIGITS - 1);

endmodule

`default_nettype wire

// File: hdl/digital_clock_top.sv
`timescale 1ns/10ps
`default_nettype none

module digital_clock_top
  import clock_pkg::*;
#(
  parameter int TICKS_PER_SEC = DEF_TICKS_PER_SEC,
  parameter int SCAN_DIV      = DEF_SCAN_DIV,
  parameter int DEBOUNCE_DIV  = DEF_DEBOUNCE_DIV
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          i_btn_mode,
  input  logic          i_btn_pos,
  input  logic          i_btn_inc,
  input  logic          i_btn_alarm,
  output seg_pattern_t  o_seg,
  output digit_enable_t o_seg_enb,
  output logic          o_alarm
);

  logic        sec_tick;
  logic        scan_tick;
  logic        sample_tick;
  logic        mode_press;
  logic        pos_press;
  logic        inc_press;
  logic        alarm_press;
  logic        time_run;
  logic        time_inc_sec;
  logic        time_inc_min;
  logic        time_inc_hour;
  logic        alarm_inc_sec;
  logic        alarm_inc_min;
  logic        alarm_inc_hour;
  logic        alarm_en;
  logic        show_alarm;
  time_field_t time_sec;
  time_field_t time_min;
  time_field_t time_hour;
  time_field_t alarm_sec;
  time_field_t alarm_min;
  time_field_t alarm_hour;

  // ------------------------------------------------------------------
  // Enable ticks and buttons
  // ------------------------------------------------------------------
  tick_gen #(.DIV(TICKS_PER_SEC)) sec_tick_inst (
    .clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
  tick_gen #(.DIV(SCAN_DIV)) scan_tick_inst (
    .clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
  tick_gen #(.DIV(DEBOUNCE_DIV)) sample_tick_inst (
    .clk(clk), .rst_n(rst_n), .o_tick(sample_tick));

  button_sync mode_btn_inst (.clk(clk), .rst_n(rst_n), .i_btn(i_btn_mode),
    .i_sample_tick(sample_tick), .o_press(mode_press));
  button_sync pos_btn_inst (.clk(clk), .rst_n(rst_n), .i_btn(i_btn_pos),
    .i_sample_tick(sample_tick), .o_press(pos_press));
  button_sync inc_btn_inst (.clk(clk), .rst_n(rst_n), .i_btn(i_btn_inc),
    .i_sample_tick(sample_tick), .o_press(inc_press));
  button_sync alarm_btn_inst (.clk(clk), .rst_n(rst_n), .i_btn(i_btn_alarm),
    .i_sample_tick(sample_tick), .o_press(alarm_press));

  // ------------------------------------------------------------------
  // Control, counters, alarm and display
  // ------------------------------------------------------------------
  mode_ctrl mode_ctrl_inst (
    .clk(clk), .rst_n(rst_n), .i_sec_tick(sec_tick),
    .i_mode_press(mode_press), .i_pos_press(pos_press),
    .i_inc_press(inc_press), .i_alarm_press(alarm_press),
    .o_time_run(time_run), .o_time_inc_sec(time_inc_sec),
    .o_time_inc_min(time_inc_min), .o_time_inc_hour(time_inc_hour),
    .o_alarm_inc_sec(alarm_inc_sec), .o_alarm_inc_min(alarm_inc_min),
    .o_alarm_inc_hour(alarm_inc_hour), .o_alarm_en(alarm_en),
    .o_show_alarm(show_alarm));

  hms_counter #(.FREE_RUN(1'b1)) time_cnt_inst (
    .clk(clk), .rst_n(rst_n), .i_run(time_run),
    .i_inc_sec(time_inc_sec), .i_inc_min(time_inc_min), .i_inc_hour(time_inc_hour),
    .o_sec(time_sec), .o_min(time_min), .o_hour(time_hour));

  hms_counter #(.FREE_RUN(1'b0)) alarm_cnt_inst (
    .clk(clk), .rst_n(rst_n), .i_run(1'b0),
    .i_inc_sec(alarm_inc_sec), .i_inc_min(alarm_inc_min), .i_inc_hour(alarm_inc_hour),
    .o_sec(alarm_sec), .o_min(alarm_min), .o_hour(alarm_hour));

  alarm_match alarm_match_inst (
    .clk(clk), .rst_n(rst_n), .i_alarm_en(alarm_en),
    .i_sec(time_sec), .i_min(time_min), .i_hour(time_hour),
    .i_alarm_sec(alarm_sec), .i_alarm_min(alarm_min), .i_alarm_hour(alarm_hour),
    .o_alarm(o_alarm));

  seg_display seg_display_inst (
    .clk(clk), .rst_n(rst_n), .i_scan_tick(scan_tick), .i_show_alarm(show_alarm),
    .i_sec(time_sec), .i_min(time_min), .i_hour(time_hour),
    .i_alarm_sec(alarm_sec), .i_alarm_min(alarm_min), .i_alarm_hour(alarm_hour),
    .o_seg(o_seg), .o_seg_enb(o_seg_enb));

endmodule

`default_nettype wire

// File: verif/tb_digital_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_digital_clock
  import clock_pkg::*;
();

  localparam int TPS = 400;
  localparam int BTN_MODE = 0;
  localparam int BTN_POS = 1;
  localparam int BTN_INC = 2;
  localparam int BTN_ALARM = 3;
  // Each press is 40 cycles held plus 40 released
  localparam int PRESS_CYCLES = 80;
  // Setting fields four times plus setup, mode and alarm presses
  localparam int MAX_PRESSES = 700;
  localparam int WAIT_CYCLES = 40 * TPS;
  localparam int READ_CYCLES = 40 * 100;
  localparam int TIMEOUT_CYCLES =
    2 * (16 + MAX_PRESSES * PRESS_CYCLES + WAIT_CYCLES + READ_CYCLES);

  logic          clk = 1'b0;
  logic          rst_n;
  logic [3:0]    btn;
  seg_pattern_t  o_seg;
  digit_enable_t o_seg_enb;
  logic          o_alarm;

  int            mismatch_count = 0;
  int            fail_count = 0;
  int            cycle_count = 0;
  integer        seed;
  logic          scan_check_en;
  digit_enable_t prev_enb;
  seg_pattern_t  seg_pat [NUM_DIGITS];
  clock_mode_t   cur_mode = MODE_CLOCK;
  set_pos_t      cur_pos = POS_SEC;

  digital_clock_top #(
    .TICKS_PER_SEC(TPS),
    .SCAN_DIV(4),
    .DEBOUNCE_DIV(8)
  ) digital_clock_top_inst (
    .clk(clk), .rst_n(rst_n),
    .i_btn_mode(btn[BTN_MODE]), .i_btn_pos(btn[BTN_POS]),
    .i_btn_inc(btn[BTN_INC]), .i_btn_alarm(btn[BTN_ALARM]),
    .o_seg(o_seg), .o_seg_enb(o_seg_enb), .o_alarm(o_alarm));

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles, the run did not finish", cycle_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Reference functions
  // ----------------------------------------------------------------------
  function automatic seg_pattern_t digit_seg(bcd_digit_t d);
    case (d)
      4'd0:    return 7'b111_1110;
      4'd1:    return 7'b011_0000;
      4'd2:    return 7'b110_1101;
      4'd3:    return 7'b111_1001;
      4'd4:    return 7'b011_0011;
      4'd5:    return 7'b101_1011;
      4'd6:    return 7'b101_1111;
      4'd7:    return 7'b111_0000;
      4'd8:    return 7'b111_1111;
      4'd9:    return 7'b111_0011;
      default: return 7'b000_0000;
    endcase
  endfunction

  function automatic int seg_digit(seg_pattern_t p);
    for (int d = 0; d < 10; d++) begin
      if (digit_seg(bcd_digit_t'(d)) == p) return d;
    end
    return -1;
  endfunction

  // Single zero walks one digit to the left
  function automatic digit_enable_t next_enb(digit_enable_t prev);
    return {prev[NUM_DIGITS-2:0], prev[NUM_DIGITS-1]};
  endfunction

  function automatic int enb_index(digit_enable_t enb);
    for (int i = 0; i < NUM_DIGITS; i++) begin
      if (enb == ~(digit_enable_t'(1) << i)) return i;
    end
    return -1;
  endfunction

  // Packed as {hours, minutes, seconds}
  function automatic logic [17:0] advance_time(time_field_t h, time_field_t m,
                                               time_field_t s, int k);
    int hh;
    int mm;
    int ss;
    hh = int'(h);
    mm = int'(m);
    ss = int'(s);
    for (int i = 0; i < k; i++) begin
      ss++;
      if (ss > 59) begin
        ss = 0;
        mm++;
      end
      if (mm > 59) begin
        mm = 0;
        hh++;
      end
      if (hh > 23) hh = 0;
    end
    return {time_field_t'(hh), time_field_t'(mm), time_field_t'(ss)};
  endfunction

  function automatic int day_seconds(time_field_t h, time_field_t m, time_field_t s);
    return int'(h) * 3600 + int'(m) * 60 + int'(s);
  endfunction

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_seg(input seg_pattern_t act, input seg_pattern_t exp,
                           input string name);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, act, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_enb(input digit_enable_t act, input digit_enable_t exp,
                           input string name);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, act, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_field(input time_field_t act, input time_field_t exp,
                             input string name);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_alarm(input logic act, input logic exp, input string name);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, act, exp);
      mismatch_count++;
    end
  endtask

  // Scan order and digit validity checked on every cycle
  always @(negedge clk) begin
    if (scan_check_en) begin
      if (o_seg_enb != prev_enb) begin
        check_enb(o_seg_enb, next_enb(prev_enb), "o_seg_enb");
      end
      if (seg_digit(o_seg) < 0) begin
        $display("ERROR at %0t: o_seg pattern %b is not a decimal digit", $time, o_seg);
        fail_count++;
      end
    end
    prev_enb = o_seg_enb;
  end

  // ----------------------------------------------------------------------
  // Buttons and display reading
  // ----------------------------------------------------------------------
  task automatic press(input int which);
    @(posedge clk);
    btn[which] <= 1'b1;
    repeat (40) @(posedge clk);
    btn[which] <= 1'b0;
    repeat (40) @(posedge clk);
  endtask

  task automatic press_inc(input int n);
    repeat (n) press(BTN_INC);
  endtask

  task automatic goto_mode(input clock_mode_t target);
    while (cur_mode != target) begin
      press(BTN_MODE);
      cur_mode = cur_mode.next();
    end
  endtask

  task automatic goto_pos(input set_pos_t target);
    while (cur_pos != target) begin
      press(BTN_POS);
      cur_pos = cur_pos.next();
    end
  endtask

  task automatic scan_once;
    logic [NUM_DIGITS-1:0] seen;
    int idx;
    int n;
    seen = '0;
    n = 0;
    while (seen != 6'h3f && n < 64) begin
      @(negedge clk);
      n++;
      idx = enb_index(o_seg_enb);
      if (idx >= 0) begin
        seg_pat[idx] = o_seg;
        seen[idx] = 1'b1;
      end
    end
    if (seen != 6'h3f) begin
      $display("ERROR at %0t: display scan did not reach all six digits", $time);
      fail_count++;
    end
  endtask

  task automatic decode_scan(output time_field_t h, output time_field_t m,
                             output time_field_t s);
    int d [NUM_DIGITS];
    for (int i = 0; i < NUM_DIGITS; i++) begin
      d[i] = seg_digit(seg_pat[i]);
      if (d[i] < 0) begin
        $display("ERROR at %0t: pattern %b on digit %0d decodes to no digit",
                 $time, seg_pat[i], i);
        fail_count++;
        d[i] = 0;
      end
    end
    s = time_field_t'(d[1] * 10 + d[0]);
    m = time_field_t'(d[3] * 10 + d[2]);
    h = time_field_t'(d[5] * 10 + d[4]);
  endtask

  // Two equal scans in a row so a second tick mid scan is not misread
  task automatic read_display(output time_field_t h, output time_field_t m,
                              output time_field_t s);
    time_field_t ph;
    time_field_t pm;
    time_field_t ps;
    int tries;
    scan_once();
    decode_scan(h, m, s);
    tries = 0;
    do begin
      ph = h;
      pm = m;
      ps = s;
      scan_once();
      decode_scan(h, m, s);
      tries++;
    end while ((h != ph || m != pm || s != ps) && tries < 4);
    if (h != ph || m != pm || s != ps) begin
      $display("ERROR at %0t: displayed time did not settle between scans", $time);
      fail_count++;
    end
  endtask

  task automatic set_fields(input time_field_t h, input time_field_t m,
                            input time_field_t s);
    time_field_t ch;
    time_field_t cm;
    time_field_t cs;
    read_display(ch, cm, cs);
    goto_pos(POS_SEC);
    press_inc((int'(s) - int'(cs) + 60) % 60);
    goto_pos(POS_MIN);
    press_inc((int'(m) - int'(cm) + 60) % 60);
    goto_pos(POS_HOUR);
    press_inc((int'(h) - int'(ch) + 24) % 24);
    read_display(ch, cm, cs);
    check_field(ch, h, "hours");
    check_field(cm, m, "minutes");
    check_field(cs, s, "seconds");
  endtask

  task automatic wait_sec_change;
    seg_pattern_t first;
    int n;
    n = 0;
    @(negedge clk);
    while (o_seg_enb != 6'b111110) @(negedge clk);
    first = o_seg;
    while (!(o_seg_enb == 6'b111110 && o_seg != first) && n < 2 * TPS) begin
      @(negedge clk);
      n++;
    end
    if (n >= 2 * TPS) begin
      $display("ERROR at %0t: seconds digit did not change within two seconds", $time);
      fail_count++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    time_field_t h0;
    time_field_t m0;
    time_field_t s0;
    time_field_t h;
    time_field_t m;
    time_field_t s;
    logic [17:0] exp_t;
    logic        seen_high;
    int          k;
    int          c1;
    int          elapsed;
    int          exp_s;
    rst_n = 1'b0;
    btn = '0;
    scan_check_en = 1'b0;
    seed = 32'hbe2ff555;
    repeat (15) @(posedge clk);
    @(negedge clk);
    check_enb(o_seg_enb, 6'b111110, "o_seg_enb");
    check_alarm(o_alarm, 1'b0, "o_alarm");
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    scan_check_en <= 1'b1;

    // Reset state shows 00:00:00
    scan_once();
    for (int i = 0; i < NUM_DIGITS; i++) begin
      check_seg(seg_pat[i], digit_seg(4'd0), "o_seg");
    end
    check_alarm(o_alarm, 1'b0, "o_alarm");

    // Minute increments in setup with no carry past 59
    goto_mode(MODE_SETUP);
    read_display(h0, m0, s0);
    goto_pos(POS_MIN);
    k = 60 + int'($unsigned($random(seed)) % 8);
    press_inc(k);
    read_display(h, m, s);
    check_field(h, h0, "hours");
    check_field(m, time_field_t'(k % 60), "minutes");
    check_field(s, s0, "seconds");
    repeat (3 * TPS) @(posedge clk);
    read_display(h0, m0, s0);
    check_field(h0, h, "hours");
    check_field(m0, m, "minutes");
    check_field(s0, s, "seconds");

    // Run across midnight
    set_fields(6'd23, 6'd59, 6'd50);
    goto_mode(MODE_CLOCK);
    wait_sec_change();
    read_display(h0, m0, s0);
    repeat (15 * TPS) @(posedge clk);
    read_display(h, m, s);
    exp_t = advance_time(h0, m0, s0, 15);
    check_field(h, exp_t[17:12], "hours");
    check_field(m, exp_t[11:6], "minutes");
    check_field(s, exp_t[5:0], "seconds");

    // Alarm fields set while the time keeps running
    c1 = cycle_count;
    goto_mode(MODE_ALARM);
    set_fields(6'd1, 6'd2, 6'd3);
    // Several seconds spent in alarm-set mode
    repeat (4 * TPS) @(posedge clk);
    goto_mode(MODE_CLOCK);
    read_display(h0, m0, s0);
    elapsed = (day_seconds(h0, m0, s0) - day_seconds(h, m, s) + 86400) % 86400;
    exp_s = (cycle_count - c1) / TPS;
    if (elapsed < exp_s - 2 || elapsed > exp_s + 2) begin
      $display("ERROR at %0t: time advanced %0d s over %0d cycles in alarm-set mode",
               $time, elapsed, cycle_count - c1);
      fail_count++;
    end

    // Enabled alarm latches on the match
    goto_mode(MODE_SETUP);
    set_fields(6'd1, 6'd1, 6'd59);
    press(BTN_ALARM);
    goto_mode(MODE_CLOCK);
    @(negedge clk);
    check_alarm(o_alarm, 1'b0, "o_alarm");
    repeat (6 * TPS) @(negedge clk);
    check_alarm(o_alarm, 1'b1, "o_alarm");
    repeat (2 * TPS) @(negedge clk);
    check_alarm(o_alarm, 1'b1, "o_alarm");
    press(BTN_ALARM);
    @(negedge clk);
    check_alarm(o_alarm, 1'b0, "o_alarm");

    // Same match with the alarm off
    goto_mode(MODE_SETUP);
    set_fields(6'd1, 6'd1, 6'd59);
    goto_mode(MODE_CLOCK);
    seen_high = 1'b0;
    repeat (6 * TPS) begin
      @(negedge clk);
      seen_high = seen_high | o_alarm;
    end
    check_alarm(seen_high, 1'b0, "o_alarm");

    $display("Run finished: %0d mismatches, %0d other errors", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hdl/clock_pkg.sv
hdl/tick_gen.sv
hdl/button_sync.sv
hdl/mode_ctrl.sv
hdl/hms_counter.sv
hdl/alarm_match.sv
hdl/seg_display.sv
hdl/digital_clock_top.sv
verif/tb_digital_clock.sv

// File: Makefile
TOP := tb_digital_clock

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null

clean:
	rm -rf obj_dir
